//--- all.f
src/srl_test_pkg.sv
src/sys_ctrl.sv
src/addr_shift_reg.sv
src/srl_shift_tester.sv
src/srl_test_top.sv
dv/srl_test_chk.sv
dv/srl_test_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the shift-register test with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module srl_test_tb -f all.f -o srl_test_sim

./obj_dir/srl_test_sim | tee sim.log

if grep -q '^SIMULATION PASSED$' sim.log; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi

//--- dv/srl_test_tb.sv
`timescale 1ns/1ps

// Testbench for the shift-register test top level.
// A cycle model of the housekeeping block, the testers and the chains runs next
// to the DUT and predicts every LED, while the tests drive the panel switches.
module srl_test_tb;

  localparam int SRLS_IN_CHAIN = 2;
  localparam int CHAIN_COUNT   = 2;
  localparam int PRESCALER     = 4;
  localparam int LENGTH        = srl_test_pkg::SRL_WORDS * SRLS_IN_CHAIN;
  localparam int ROUND_CYCLES  = 2 * LENGTH * PRESCALER;
  // fifteen rounds cover all tests including their phase alignment.
  localparam int TEST_CYCLES   = 15 * ROUND_CYCLES + 32;
  localparam int CYCLE_LIMIT   = TEST_CYCLES + TEST_CYCLES / 5;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 rx;
  logic                 tx;
  srl_test_pkg::panel_t sw;
  srl_test_pkg::panel_t led;

  // the model state is updated on every rising edge.
  int                   m_stretch = 4;
  int                   m_pc = 0;
  logic                 m_tick = 1'b0;
  logic [3:0]           m_blink = 4'd0;
  logic                 m_read = 1'b0;
  int                   m_cnt = 0;
  srl_test_pkg::lfsr_t  m_wr = srl_test_pkg::LFSR_SEED;
  srl_test_pkg::lfsr_t  m_rd = srl_test_pkg::LFSR_SEED;
  logic                 m_err = 1'b0;
  logic                 m_lat = 1'b0;
  logic [LENGTH-1:0]    m_chain = '0;

  logic [31:0]          rng_state = 32'd44;
  logic                 checks_on = 1'b0;
  int                   cycles = 0;
  int                   errors = 0;
  int                   tests_run = 0;
  int                   tests_failed = 0;
  int                   pat_age = 0;
  int                   pat_period = 48;
  int                   lit_cycles = 0;
  int                   unlit_cycles = 0;
  int                   pulses0 = 0;
  int                   pulses1 = 0;
  int                   read_checks = 0;
  int                   inv_cycles = 0;
  int                   plain_cycles = 0;

  srl_test_top #(
    .SRLS_IN_CHAIN (SRLS_IN_CHAIN),
    .CHAIN_COUNT   (CHAIN_COUNT),
    .PRESCALER     (PRESCALER)
  ) u_dut (
    .clk (clk),
    .rst (rst),
    .rx  (rx),
    .tx  (tx),
    .sw  (sw),
    .led (led)
  );

  bind srl_shift_tester srl_test_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .ce        (ce),
    .srl_sh    (srl_sh),
    .error     (error),
    .error_lat (error_lat),
    .state     (state)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // The LFSR x^16+x^14+x^13+x^11+1 shifts left and feeds back into bit 0.
  function automatic srl_test_pkg::lfsr_t lfsr_next(input srl_test_pkg::lfsr_t s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic report_value(input string sig, input logic [15:0] exp, input logic [15:0] act);
    $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
    errors++;
  endtask

  task automatic report_text(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  // One clock cycle. Inputs change 1 ns after the edge; rx is new every
  // cycle and the upper switches change every pat_period cycles.
  task automatic advance();
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = next_rand();
    rx = r[0];
    pat_age++;
    if (pat_age >= pat_period) begin
      pat_age = 0;
      r = next_rand();
      if (r[31:30] == 2'b00) begin
        sw[15:3] = '0;
      end else begin
        sw[15:3] = r[12:0];
      end
    end
  endtask

  // Advance until the model has just entered the given phase.
  task automatic wait_phase_start(input logic want_read);
    while (m_read == want_read) begin
      advance();
    end
    while (m_read != want_read) begin
      advance();
    end
  endtask

  always @(posedge clk) begin : model_update
    logic sr;
    logic mis;
    sr  = rst | sw[0] | (m_stretch != 0);
    mis = (m_chain[LENGTH-1-m_cnt] ^ sw[2]) != m_rd[15];
    // the chain has no reset and shifts on every fill tick.
    if (m_tick && !m_read) begin
      m_chain = {m_chain[LENGTH-2:0], m_wr[15]};
    end
    if (sr) begin
      m_read = 1'b0;
      m_cnt  = 0;
      m_wr   = srl_test_pkg::LFSR_SEED;
      m_rd   = srl_test_pkg::LFSR_SEED;
      m_err  = 1'b0;
      m_lat  = 1'b0;
    end else begin
      m_lat = m_lat | m_err;
      m_err = m_tick && m_read && mis;
      if (m_tick) begin
        if (m_read) begin
          m_rd = lfsr_next(m_rd);
        end else begin
          m_wr = lfsr_next(m_wr);
        end
        if (m_cnt == LENGTH - 1) begin
          m_cnt  = 0;
          m_read = !m_read;
        end else begin
          m_cnt++;
        end
      end
    end
    if (sr) begin
      m_pc    = 0;
      m_tick  = 1'b0;
      m_blink = 4'd0;
    end else begin
      if (m_tick) begin
        m_blink = m_blink + 4'd1;
      end
      if (m_pc == PRESCALER - 1) begin
        m_pc   = 0;
        m_tick = 1'b1;
      end else begin
        m_pc++;
        m_tick = 1'b0;
      end
    end
    if (rst || sw[0]) begin
      m_stretch = 4;
    end else if (m_stretch != 0) begin
      m_stretch--;
    end
    checks_on = 1'b1;
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // outputs are compared in the middle of the cycle, well away from both
  // the clock edge and the input changes.
  always @(negedge clk) begin : output_check
    logic exp_err;
    logic exp_hb;
    if (checks_on) begin
      exp_err = sw[1] ? m_lat : m_err;
      if (led[1:0] !== {exp_err, exp_err}) begin
        report_value("led[1:0]", 16'({exp_err, exp_err}), 16'(led[1:0]));
      end
      if (led[13:2] !== {12{exp_err}}) begin
        report_value("led[13:2]", 16'({12{exp_err}}), 16'(led[13:2]));
      end
      exp_hb = m_blink[3] ^ (|sw[15:3]);
      if (led[15] !== exp_hb) begin
        report_value("led[15]", 16'(exp_hb), 16'(led[15]));
      end
      if (tx !== rx) begin
        report_value("tx", 16'(rx), 16'(tx));
      end
      if (m_tick && m_read) begin
        if (led[14] !== m_rd[15]) begin
          report_value("led[14]", 16'(m_rd[15]), 16'(led[14]));
        end else begin
          read_checks++;
        end
      end
      if (led[13:0] != 14'd0) begin
        lit_cycles++;
      end
      if (led[1:0] != 2'b11) begin
        unlit_cycles++;
      end
      if (led[0]) begin
        pulses0++;
      end
      if (led[1]) begin
        pulses1++;
      end
      if (|sw[15:3]) begin
        inv_cycles++;
      end else begin
        plain_cycles++;
      end
    end
  end

  task automatic clean_rounds(input string name);
    int start;
    start = errors;
    sw[2:0] = 3'b000;
    lit_cycles = 0;
    repeat (3) wait_phase_start(1'b0);
    if (lit_cycles != 0) begin
      report_text("error LEDs lit during clean rounds");
    end
    end_test(name, start);
  endtask

  task automatic inject_fault();
    int          start;
    int          covered;
    logic [31:0] r;
    start = errors;
    sw[1] = 1'b0;
    wait_phase_start(1'b1);
    r = next_rand();
    covered = r[0] ? 2 : 1;
    pulses0 = 0;
    pulses1 = 0;
    sw[2] = 1'b1;
    repeat (covered) wait_phase_start(1'b1);
    sw[2] = 1'b0;
    wait_phase_start(1'b1);
    if (pulses0 != covered * LENGTH) begin
      report_value("led[0] pulse count", 16'(covered * LENGTH), 16'(pulses0));
    end
    if (pulses1 != covered * LENGTH) begin
      report_value("led[1] pulse count", 16'(covered * LENGTH), 16'(pulses1));
    end
    end_test("fault injection", start);
  endtask

  task automatic hold_sticky_flags();
    int start;
    start = errors;
    sw[1] = 1'b1;
    advance();
    if (led[1:0] !== 2'b11) begin
      report_text("sticky error flags are not set after the fault");
    end
    unlit_cycles = 0;
    wait_phase_start(1'b1);
    if (unlit_cycles != 0) begin
      report_text("sticky error flags dropped during a clean round");
    end
    sw[0] = 1'b1;
    advance();
    sw[0] = 1'b0;
    repeat (6) advance();
    if (led[1:0] !== 2'b00) begin
      report_value("led[1:0]", 16'd0, 16'(led[1:0]));
    end
    sw[1] = 1'b0;
    end_test("sticky display and panel reset", start);
  endtask

  task automatic watch_heartbeat();
    int start;
    start = errors;
    pat_period = 16;
    inv_cycles = 0;
    plain_cycles = 0;
    repeat (2) wait_phase_start(1'b1);
    pat_period = 48;
    if (inv_cycles == 0 || plain_cycles == 0) begin
      report_text("heartbeat was not seen both plain and inverted");
    end
    end_test("heartbeat", start);
  endtask

  // every read tap of one full round has to match the checker stream.
  task automatic verify_readback();
    int start;
    start = errors;
    wait_phase_start(1'b1);
    read_checks = 0;
    wait_phase_start(1'b1);
    if (read_checks != LENGTH) begin
      report_value("matching read taps", 16'(LENGTH), 16'(read_checks));
    end
    end_test("read-back data and loopback", start);
  endtask

  initial begin
    rst = 1'b1;
    rx  = 1'b0;
    sw  = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    clean_rounds("clean rounds after reset");
    inject_fault();
    hold_sticky_flags();
    clean_rounds("clean rounds after panel reset");
    watch_heartbeat();
    verify_readback();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- dv/srl_test_chk.sv
`timescale 1ns/1ps

// Assertions on the control outputs of one shift tester.
// An instance sits inside every srl_shift_tester and watches its ports and
// its state register.
module srl_test_chk (
  input logic                        clk,
  input logic                        rst,
  input logic                        ce,
  input logic                        srl_sh,
  input logic                        error,
  input logic                        error_lat,
  input srl_test_pkg::tester_state_e state
);

  // the chain may only shift on an enable tick of the fill phase.
  // A tick lasts a single cycle, so a shift is never followed by another.
  sh_only_on_fill_tick: assert property (
    @(posedge clk) srl_sh |=> !srl_sh && ($past(state) == srl_test_pkg::ST_FILL)
  ) else begin
    $error("srl_sh high outside a fill tick");
  end

  // A live error pulse is the registered result of a compare tick, so a
  // cycle without an enable can never be followed by one.
  error_after_tick: assert property (
    @(posedge clk) !ce |=> !error
  ) else begin
    $error("error pulse without a preceding tick");
  end

  // only a reset clears the sticky flag.
  sticky_holds: assert property (
    @(posedge clk) (error_lat && !rst) |=> error_lat
  ) else begin
    $error("error_lat fell while reset was low");
  end

endmodule

//--- src/srl_test_top.sv
`timescale 1ns/1ps

// Board top level for the shift-register test.
// Each lane pairs a tester with its own chain. The panel switches give a
// reset, the choice of live or sticky error display, fault injection and
// heartbeat inversion.
module srl_test_top #(
  parameter int SRLS_IN_CHAIN = 2,
  parameter int CHAIN_COUNT   = 1,
  parameter int PRESCALER     = 1000000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx,
  output logic                 tx,
  input  srl_test_pkg::panel_t sw,
  output srl_test_pkg::panel_t led
);

  // Number of taps in one chain.
  localparam int LENGTH = srl_test_pkg::SRL_WORDS * SRLS_IN_CHAIN;

  logic                   sys_rst;
  logic                   tick;
  logic                   heartbeat;
  logic [CHAIN_COUNT-1:0] srl_q;
  logic [CHAIN_COUNT-1:0] error;
  logic [CHAIN_COUNT-1:0] error_lat;
  logic [CHAIN_COUNT-1:0] lane_led;

  // The serial port only loops back.
  assign tx = rx;

  sys_ctrl #(
    .PRESCALER (PRESCALER)
  ) u_sys_ctrl (
    .clk       (clk),
    .rst       (rst),
    .panel_rst (sw[0]),
    .sys_rst   (sys_rst),
    .tick      (tick),
    .heartbeat (heartbeat)
  );

  for (genvar i = 0; i < CHAIN_COUNT; i++) begin : g_lane
    logic                srl_sh;
    logic                srl_d;
    srl_test_pkg::addr_t srl_a;

    // sw[2] inverts every read-back bit, so each read fails.
    srl_shift_tester #(
      .LENGTH (LENGTH)
    ) u_tester (
      .clk       (clk),
      .rst       (sys_rst),
      .ce        (tick),
      .q_in      (srl_q[i] ^ sw[2]),
      .srl_sh    (srl_sh),
      .srl_d     (srl_d),
      .srl_a     (srl_a),
      .error     (error[i]),
      .error_lat (error_lat[i])
    );

    addr_shift_reg #(
      .LENGTH (LENGTH)
    ) u_chain (
      .clk (clk),
      .sh  (srl_sh),
      .d   (srl_d),
      .a   (srl_a),
      .q   (srl_q[i])
    );
  end

  // one LED per lane, sticky when sw[1] is up.
  assign lane_led = sw[1] ? error_lat : error;

  // the last lane is repeated over the unused error LEDs.
  assign led[CHAIN_COUNT-1:0] = lane_led;
  assign led[13:CHAIN_COUNT]  = {(14 - CHAIN_COUNT){lane_led[CHAIN_COUNT-1]}};

  // Raw chain 0 output, before fault injection.
  assign led[14] = srl_q[0];

  // Any of the upper switches inverts the heartbeat.
  assign led[15] = heartbeat ^ (|sw[15:3]);

endmodule

//--- src/srl_shift_tester.sv
`timescale 1ns/1ps

// Self-checking tester for one shift-register chain.
// In the fill phase it shifts a pseudo-random stream into the chain, one bit
// per enable tick. In the read phase it walks the taps from the oldest bit
// to the newest and compares each one with a second copy of the same
// stream. A mismatch gives a one-cycle error pulse and sets the sticky flag.
module srl_shift_tester #(
  parameter int LENGTH = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ce,
  input  logic                q_in,
  output logic                srl_sh,
  output logic                srl_d,
  output srl_test_pkg::addr_t srl_a,
  output logic                error,
  output logic                error_lat
);

  localparam srl_test_pkg::addr_t LAST = srl_test_pkg::addr_t'(LENGTH - 1);

  srl_test_pkg::tester_state_e state;
  srl_test_pkg::addr_t         cnt;
  srl_test_pkg::lfsr_t         wr_lfsr;
  srl_test_pkg::lfsr_t         rd_lfsr;
  logic                        last_step;
  logic                        rd_tick;
  logic                        mismatch;

  // One step of the LFSR, x^16+x^14+x^13+x^11+1.
  function automatic srl_test_pkg::lfsr_t lfsr_step(input srl_test_pkg::lfsr_t s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // the stream bit is the top bit before the step.
  assign srl_d = wr_lfsr[15];

  // shift only on a tick of the fill phase.
  assign srl_sh = ce && (state == srl_test_pkg::ST_FILL);

  // The newest bit sits at tap 0, so counting the address down from the top
  // reads the bits back in the order they were written.
  assign srl_a = LAST - cnt;

  assign rd_tick   = ce && (state == srl_test_pkg::ST_READ);
  assign mismatch  = q_in != rd_lfsr[15];
  assign last_step = cnt == LAST;

  // phase sequencing and the lap counter.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= srl_test_pkg::ST_FILL;
      cnt   <= '0;
    end else if (ce) begin
      if (last_step) begin
        cnt <= '0;
        if (state == srl_test_pkg::ST_FILL) begin
          state <= srl_test_pkg::ST_READ;
        end else begin
          state <= srl_test_pkg::ST_FILL;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // writer LFSR, stepped once per shifted bit.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_lfsr <= srl_test_pkg::LFSR_SEED;
    end else if (srl_sh) begin
      wr_lfsr <= lfsr_step(wr_lfsr);
    end
  end

  // Checker LFSR, stepped once per read tap.
  // Both LFSRs restart from the seed together, so every read phase expects
  // exactly the stream of the fill phase before it.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_lfsr <= srl_test_pkg::LFSR_SEED;
    end else if (rd_tick) begin
      rd_lfsr <= lfsr_step(rd_lfsr);
    end
  end

  // live error pulse in the cycle after a failed comparison, and the sticky
  // copy that only a reset clears.
  always_ff @(posedge clk) begin
    if (rst) begin
      error     <= 1'b0;
      error_lat <= 1'b0;
    end else begin
      error     <= rd_tick && mismatch;
      error_lat <= error_lat | error;
    end
  end

endmodule

//--- src/addr_shift_reg.sv
`timescale 1ns/1ps

// Behavioural model of a cascaded chain of addressable shift-register
// primitives. Data enters at bit 0 and moves up one place per shift.
// Any tap of the chain can be read combinationally through the address.
module addr_shift_reg #(
  parameter int LENGTH = 64
) (
  input  logic                clk,
  input  logic                sh,
  input  logic                d,
  input  srl_test_pkg::addr_t a,
  output logic                q
);

  // the address space covers 128 taps.
  // Taps beyond the end of the chain read as zero.
  localparam int TAPS = 2 ** $bits(srl_test_pkg::addr_t);

  logic [LENGTH-1:0] chain;
  logic [TAPS-1:0]   tap_vec;

  // The primitive has no reset, so the chain powers up with whatever the
  // fill phase puts into it.
  always_ff @(posedge clk) begin
    if (sh) begin
      chain <= {chain[LENGTH-2:0], d};
    end
  end

  // Widen the chain to the full address range so that every address
  // selects a defined bit.
  assign tap_vec = TAPS'(chain);

  // asynchronous tap read, like the A port of the primitive.
  assign q = tap_vec[a];

endmodule

//--- src/sys_ctrl.sv
`timescale 1ns/1ps

// Board housekeeping: reset stretching, the slow enable tick and the
// heartbeat counter that blinks an LED.
module sys_ctrl #(
  parameter int PRESCALER = 1000000
) (
  input  logic clk,
  input  logic rst,
  input  logic panel_rst,
  output logic sys_rst,
  output logic tick,
  output logic heartbeat
);

  // one extra bit catches the underflow of the down counter.
  localparam int CW = $clog2(PRESCALER) + 1;
  localparam logic [CW-1:0] PS_LOAD = CW'(PRESCALER - 2);

  logic [3:0]    rst_sr;
  logic [CW-1:0] ps_cnt;
  logic          ps_wrap;
  logic [3:0]    blink_cnt;

  // Either reset source reloads the stretcher; it then drains one bit per
  // cycle, which keeps sys_rst high for four cycles after both are low.
  always_ff @(posedge clk) begin
    if (rst || panel_rst) begin
      rst_sr <= 4'hf;
    end else begin
      rst_sr <= rst_sr >> 1;
    end
  end

  assign sys_rst = rst | panel_rst | rst_sr[0];

  // the counter runs from PRESCALER-2 down past zero.
  // The wrap to all ones sets the top bit and marks the end of a period.
  assign ps_wrap = ps_cnt[CW-1];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      ps_cnt <= PS_LOAD;
      tick   <= 1'b0;
    end else begin
      tick <= ps_wrap;
      if (ps_wrap) begin
        ps_cnt <= PS_LOAD;
      end else begin
        ps_cnt <= ps_cnt - 1'b1;
      end
    end
  end

  // heartbeat toggles every eight ticks.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      blink_cnt <= '0;
    end else if (tick) begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  assign heartbeat = blink_cnt[3];

endmodule

//--- src/srl_test_pkg.sv
// Shared types and constants for the shift-register test design.
// Everything here is reached by scoped names from the files that need it.
package srl_test_pkg;

  // switch and LED panel of the board, one bit per switch or LED.
  typedef logic [15:0] panel_t;

  // state of a 16-bit Fibonacci LFSR.
  // Polynomial x^16+x^14+x^13+x^11+1, shifting left.
  typedef logic [15:0] lfsr_t;

  // Tap address of a chain.
  // Seven bits limit a chain to 128 taps.
  typedef logic [6:0] addr_t;

  // Start value for the writer and checker LFSRs.
  // It must never be zero, or the LFSR locks up.
  localparam lfsr_t LFSR_SEED = 16'hace1;

  // Number of bits in one shift-register primitive.
  localparam int SRL_WORDS = 32;

  // The tester alternates between filling the chain and reading it back.
  typedef enum logic {
    ST_FILL,
    ST_READ
  } tester_state_e;

endpackage
